// File: include/rob_cfg.svh
`ifndef ROB_CFG_SVH
`define ROB_CFG_SVH

// buffer depth, power of two so tags wrap for free
`define ROB_LEN      16

// lanes for dispatch, completion and retire
`define ROB_WIDTH    3

`define ROB_XLEN     32   // result width
`define ROB_REG_BITS 5    // arch register index

`endif

// File: rtl/rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_alloc (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      squash,
    input  rob_pkg::dispatch_lane_t [`ROB_WIDTH-1:0]  dispatch_in,
    output rob_pkg::alloc_lane_t    [`ROB_WIDTH-1:0]  alloc_lanes,
    output rob_pkg::map_lane_t      [`ROB_WIDTH-1:0]  map_out
);

    rob_pkg::rob_tag_t   tail;
    rob_pkg::lane_mask_t dp_valid;   // raw per-lane strobes
    rob_pkg::lane_mask_t disp;       // dispatched prefix
    rob_pkg::lane_cnt_t  disp_cnt;

    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            dp_valid[k] = dispatch_in[k].valid;
        end
        disp     = rob_pkg::valid_prefix(dp_valid); // first invalid lane ends group
        disp_cnt = rob_pkg::lane_count(disp);
    end

    // tags straight from tail, same cycle
    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            alloc_lanes[k].valid    = disp[k];
            alloc_lanes[k].tag      = tail + rob_pkg::rob_tag_t'(k); // wraps at ROB_LEN
            alloc_lanes[k].mem_op   = dispatch_in[k].mem_op;
            // no destination -> r0
            alloc_lanes[k].dest_reg = dispatch_in[k].dest_valid ? dispatch_in[k].dest_reg : '0;

            // rename report for the map table
            map_out[k].valid    = disp[k] & dispatch_in[k].dest_valid;
            map_out[k].dest_reg = alloc_lanes[k].dest_reg;
            map_out[k].tag      = alloc_lanes[k].tag;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            tail <= '0;
        end else begin
            tail <= tail + rob_pkg::rob_tag_t'(disp_cnt);
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_entry_table.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_entry_table (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      squash,
    input  rob_pkg::alloc_lane_t    [`ROB_WIDTH-1:0]  alloc_lanes,
    input  rob_pkg::complete_lane_t [`ROB_WIDTH-1:0]  complete_in,
    input  rob_pkg::retire_lane_t   [`ROB_WIDTH-1:0]  retire_out,
    output rob_pkg::rob_entry_t     [`ROB_LEN-1:0]    entries,
    output rob_pkg::lane_cnt_t                        free_slots
);

    localparam int CNT_BITS = $clog2(`ROB_LEN + 1);

    rob_pkg::rob_entry_t [`ROB_LEN-1:0] rob_table;
    rob_pkg::lane_mask_t                cpl_valid;
    rob_pkg::lane_mask_t                cpl_mask;   // completion prefix
    logic [CNT_BITS-1:0]                free_cnt;

    assign entries = rob_table;

    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            cpl_valid[k] = complete_in[k].valid;
        end
        cpl_mask = rob_pkg::valid_prefix(cpl_valid);
    end

    // dispatch only hits free rows, completion busy ones, retire done ones,
    // so the three write groups never touch the same row in one cycle
    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            for (int i = 0; i < `ROB_LEN; i++) begin
                rob_table[i].busy <= 1'b0;
                rob_table[i].done <= 1'b0;
            end
        end else begin
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (alloc_lanes[k].valid) begin
                    rob_table[alloc_lanes[k].tag].busy     <= 1'b1;
                    rob_table[alloc_lanes[k].tag].done     <= 1'b0;
                    rob_table[alloc_lanes[k].tag].dest_reg <= alloc_lanes[k].dest_reg;
                    rob_table[alloc_lanes[k].tag].mem_op   <= alloc_lanes[k].mem_op;
                end
            end

            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (cpl_mask[k]) begin
                    rob_table[complete_in[k].tag].done        <= 1'b1;
                    rob_table[complete_in[k].tag].value       <= complete_in[k].value;
                    rob_table[complete_in[k].tag].take_branch <= complete_in[k].take_branch;
                end
            end

            // free the rows leaving at head
            for (int k = 0; k < `ROB_WIDTH; k++) begin
                if (retire_out[k].valid) begin
                    rob_table[retire_out[k].tag].busy <= 1'b0;
                    rob_table[retire_out[k].tag].done <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        free_cnt = '0;
        for (int i = 0; i < `ROB_LEN; i++) begin
            if (!rob_table[i].busy) begin
                free_cnt = free_cnt + CNT_BITS'(1);
            end
        end
    end

    // dispatch never needs more than one group's worth
    assign free_slots = (free_cnt > CNT_BITS'(`ROB_WIDTH)) ?
                        rob_pkg::lane_cnt_t'(`ROB_WIDTH) :
                        rob_pkg::lane_cnt_t'(free_cnt);

endmodule

`default_nettype wire

// File: rtl/rob_pkg.sv
`default_nettype none

`include "rob_cfg.svh"

package rob_pkg;

    typedef logic [$clog2(`ROB_LEN)-1:0]       rob_tag_t;   // entry index
    typedef logic [`ROB_REG_BITS-1:0]          reg_idx_t;
    typedef logic [`ROB_XLEN-1:0]              data_t;
    typedef logic [`ROB_WIDTH-1:0]             lane_mask_t; // one bit per lane
    typedef logic [$clog2(`ROB_WIDTH+1)-1:0]   lane_cnt_t;  // 0 .. ROB_WIDTH

    typedef struct packed {
        logic     busy;        // allocated, not yet retired
        logic     done;        // result written
        reg_idx_t dest_reg;
        logic     mem_op;      // load or store
        data_t    value;
        logic     take_branch;
    } rob_entry_t;

    typedef struct packed {
        logic     valid;
        logic     dest_valid;
        reg_idx_t dest_reg;
        logic     mem_op;
    } dispatch_lane_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t dest_reg;    // already masked by dest_valid
        logic     mem_op;
    } alloc_lane_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
        logic     take_branch;
    } complete_lane_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t dest_reg;
        data_t    value;
        logic     take_branch;
    } retire_lane_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t dest_reg;
        rob_tag_t tag;
    } map_lane_t;

    // keep lanes up to the first clear bit
    function automatic lane_mask_t valid_prefix(input lane_mask_t v);
        logic chain;
        chain = 1'b1;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            chain = chain & v[k];
            valid_prefix[k] = chain;
        end
    endfunction

    function automatic lane_cnt_t lane_count(input lane_mask_t m);
        lane_count = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            lane_count = lane_count + lane_cnt_t'(m[k]);
        end
    endfunction

endpackage

`default_nettype wire

// File: rtl/rob_retire_sel.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_retire_sel (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    squash,
    input  rob_pkg::rob_entry_t   [`ROB_LEN-1:0]    entries,
    output rob_pkg::retire_lane_t [`ROB_WIDTH-1:0]  retire_out
);

    rob_pkg::rob_tag_t                     head;
    rob_pkg::rob_tag_t   [`ROB_WIDTH-1:0]  idx;      // head, head+1, head+2
    rob_pkg::rob_entry_t [`ROB_WIDTH-1:0]  ent;      // rows under the window
    rob_pkg::lane_mask_t                   ret_mask;
    rob_pkg::lane_cnt_t                    ret_cnt;

    // in-order window at head
    // a lane retires only if all lanes below it do,
    // and only one load/store may leave per group
    always_comb begin
        logic chain;
        logic mem_seen;
        chain    = 1'b1;
        mem_seen = 1'b0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            idx[k] = head + rob_pkg::rob_tag_t'(k);
            ent[k] = entries[idx[k]];
            chain    = chain & ent[k].done & ~(mem_seen & ent[k].mem_op);
            mem_seen = mem_seen | ent[k].mem_op;
            ret_mask[k] = chain;
        end
        ret_cnt = rob_pkg::lane_count(ret_mask);
    end

    // payload fields are passed through unmasked
    always_comb begin
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            retire_out[k].valid       = ret_mask[k];
            retire_out[k].tag         = idx[k];
            retire_out[k].dest_reg    = ent[k].dest_reg;
            retire_out[k].value       = ent[k].value;
            retire_out[k].take_branch = ent[k].take_branch;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n || squash) begin
            head <= '0;
        end else begin
            head <= head + rob_pkg::rob_tag_t'(ret_cnt); // skip past retired group
        end
    end

endmodule

`default_nettype wire

// File: rtl/rob_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_top (
    input  logic                                      clock,
    input  logic                                      rst_n,
    input  logic                                      squash,
    input  rob_pkg::dispatch_lane_t [`ROB_WIDTH-1:0]  dispatch_in,
    input  rob_pkg::complete_lane_t [`ROB_WIDTH-1:0]  complete_in,
    output rob_pkg::map_lane_t      [`ROB_WIDTH-1:0]  map_out,
    output rob_pkg::retire_lane_t   [`ROB_WIDTH-1:0]  retire_out,
    output rob_pkg::lane_cnt_t                        free_slots
);

    rob_pkg::alloc_lane_t [`ROB_WIDTH-1:0] alloc_lanes;  // tagged dispatch group
    rob_pkg::rob_entry_t  [`ROB_LEN-1:0]   entries;      // full table state

    // tail side
    rob_alloc u_alloc (
        .clock       (clock),
        .rst_n       (rst_n),
        .squash      (squash),
        .dispatch_in (dispatch_in),
        .alloc_lanes (alloc_lanes),
        .map_out     (map_out)
    );

    rob_entry_table u_table (
        .clock       (clock),
        .rst_n       (rst_n),
        .squash      (squash),
        .alloc_lanes (alloc_lanes),
        .complete_in (complete_in),
        .retire_out  (retire_out),   // loops back to clear retired rows
        .entries     (entries),
        .free_slots  (free_slots)
    );

    // head side
    rob_retire_sel u_retire (
        .clock      (clock),
        .rst_n      (rst_n),
        .squash     (squash),
        .entries    (entries),
        .retire_out (retire_out)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build and run the reorder buffer testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    -f sources.f --top-module tb_rob -Mdir obj_dir -o tb_rob
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_rob +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0

// File: sim/rob_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module rob_checker (
    input logic                                      clock,
    input logic                                      rst_n,
    input logic                                      squash,
    input rob_pkg::dispatch_lane_t [`ROB_WIDTH-1:0]  dispatch_in,
    input rob_pkg::retire_lane_t   [`ROB_WIDTH-1:0]  retire_out,
    input rob_pkg::lane_cnt_t                        free_slots
);

    int         fail_count = 0;  // polled by tb_rob at the end of the run
    logic [2:0] disp_cnt;        // length of the dispatch prefix

    always_comb begin
        logic chain;
        chain    = 1'b1;
        disp_cnt = '0;
        for (int k = 0; k < `ROB_WIDTH; k++) begin
            chain    = chain & dispatch_in[k].valid;
            disp_cnt = disp_cnt + 3'(chain);
        end
    end

    // retire lanes form a prefix
    assert property (@(posedge clock) disable iff (!rst_n)
        retire_out[1].valid |-> retire_out[0].valid)
        else begin $error("retire lane 1 valid while lane 0 is not"); fail_count++; end
    assert property (@(posedge clock) disable iff (!rst_n)
        retire_out[2].valid |-> retire_out[1].valid)
        else begin $error("retire lane 2 valid while lane 1 is not"); fail_count++; end

    // producer stays within the free-slot report
    assert property (@(posedge clock) disable iff (!rst_n) disp_cnt <= {1'b0, free_slots})
        else begin $error("more lanes dispatched than free slots"); fail_count++; end

    // empty buffer after a clear
    assert property (@(posedge clock) (!rst_n || squash) |=>
        !(retire_out[0].valid || retire_out[1].valid || retire_out[2].valid))
        else begin $error("retire lane valid right after reset or squash"); fail_count++; end

endmodule

`default_nettype wire

// File: sim/tb_rob.sv
`timescale 1ns/1ns
`default_nettype none

`include "rob_cfg.svh"

module tb_rob;

    localparam int W          = `ROB_WIDTH;
    localparam int L          = `ROB_LEN;
    localparam int NUM_CYCLES = 3000;

    logic                             clock;
    logic                             rst_n;
    logic                             squash;
    rob_pkg::dispatch_lane_t [W-1:0]  dispatch_in;
    rob_pkg::complete_lane_t [W-1:0]  complete_in;
    rob_pkg::map_lane_t      [W-1:0]  map_out;
    rob_pkg::retire_lane_t   [W-1:0]  retire_out;
    rob_pkg::lane_cnt_t               free_slots;

    // reference model state
    logic              m_busy [L];
    logic              m_done [L];
    logic              m_mem  [L];
    logic              m_br   [L];
    rob_pkg::reg_idx_t m_dest [L];
    rob_pkg::data_t    m_val  [L];
    int                m_head;
    int                m_tail;
    logic [31:0]       seed;

    rob_top dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .squash      (squash),
        .dispatch_in (dispatch_in),
        .complete_in (complete_in),
        .map_out     (map_out),
        .retire_out  (retire_out),
        .free_slots  (free_slots)
    );

    bind rob_top rob_checker u_checker (
        .clock       (clock),
        .rst_n       (rst_n),
        .squash      (squash),
        .dispatch_in (dispatch_in),
        .retire_out  (retire_out),
        .free_slots  (free_slots)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;  // 20 ns period
    end

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // upper bits only, low lcg bits repeat quickly
    function automatic int rand_below(input int n);
        return int'((next_random() >> 8) % 32'(n));
    endfunction

    function automatic int count_busy();
        int n;
        n = 0;
        for (int i = 0; i < L; i++) n += m_busy[i] ? 1 : 0;
        return n;
    endfunction

    // done chain from head, at most one load/store per group
    function automatic logic [W-1:0] expected_retire();
        logic [W-1:0] m;
        logic         ok;
        int           mems;
        int           t;
        ok   = 1'b1;
        mems = 0;
        for (int k = 0; k < W; k++) begin
            t = (m_head + k) % L;
            if (m_mem[t]) mems++;
            ok   = ok & m_done[t] & (mems <= 1);
            m[k] = ok;
        end
        return m;
    endfunction

    task automatic model_clear();
        for (int i = 0; i < L; i++) begin
            m_busy[i] = 1'b0;
            m_done[i] = 1'b0;
        end
        m_head = 0;
        m_tail = 0;
    endtask

    // one rising edge, using the inputs the DUT saw before it
    task automatic model_step();
        logic [W-1:0] ret;
        logic         chain;
        int           t;
        int           n;
        ret = expected_retire();  // from state before the edge
        if (!rst_n || squash) begin
            model_clear();
        end else begin
            chain = 1'b1;
            n     = 0;
            for (int k = 0; k < W; k++) begin
                chain = chain & dispatch_in[k].valid;
                if (chain) begin
                    t         = (m_tail + k) % L;
                    m_busy[t] = 1'b1;
                    m_done[t] = 1'b0;
                    m_mem[t]  = dispatch_in[k].mem_op;
                    m_dest[t] = dispatch_in[k].dest_valid ? dispatch_in[k].dest_reg : '0;
                    n++;
                end
            end
            m_tail = (m_tail + n) % L;
            chain  = 1'b1;
            for (int k = 0; k < W; k++) begin
                chain = chain & complete_in[k].valid;
                if (chain) begin
                    t         = int'(complete_in[k].tag);
                    m_done[t] = 1'b1;
                    m_val[t]  = complete_in[k].value;
                    m_br[t]   = complete_in[k].take_branch;
                end
            end
            n = 0;
            for (int k = 0; k < W; k++) begin
                if (ret[k]) begin
                    t         = (m_head + k) % L;
                    m_busy[t] = 1'b0;
                    m_done[t] = 1'b0;
                    n++;
                end
            end
            m_head = (m_head + n) % L;
        end
    endtask

    task automatic drive_stimulus(input logic new_work);
        rob_pkg::dispatch_lane_t [W-1:0] d;
        rob_pkg::complete_lane_t [W-1:0] c;
        int                              open_tags[$];
        int                              free;
        int                              n_disp;
        int                              n_cpl;
        int                              pick;
        free = L - count_busy();
        if (free > W) free = W;
        n_disp = new_work ? rand_below(free + 1) : 0;
        for (int k = 0; k < W; k++) begin
            // lanes past the gap are noise
            d[k].valid      = (k < n_disp) || (k > n_disp && rand_below(2) == 1);
            d[k].dest_valid = rand_below(4) != 0;
            d[k].dest_reg   = rob_pkg::reg_idx_t'(rand_below(32));
            d[k].mem_op     = rand_below(3) == 0;
        end
        for (int i = 0; i < L; i++) begin
            if (m_busy[i] && !m_done[i]) open_tags.push_back(i);  // still waiting on a result
        end
        n_cpl = rand_below(W + 1);
        if (n_cpl > open_tags.size()) n_cpl = open_tags.size();
        for (int k = 0; k < W; k++) begin
            c[k].valid       = (k > n_cpl) && rand_below(2) == 1;
            c[k].tag         = rob_pkg::rob_tag_t'(rand_below(L));
            c[k].value       = next_random();
            c[k].take_branch = rand_below(2) == 1;
            if (k < n_cpl) begin
                pick       = rand_below(open_tags.size());  // distinct tags, any order
                c[k].valid = 1'b1;
                c[k].tag   = rob_pkg::rob_tag_t'(open_tags[pick]);
                open_tags.delete(pick);
            end
        end
        squash      <= new_work && rand_below(100) == 0;
        dispatch_in <= d;
        complete_in <= c;
    endtask

    task automatic expect_value(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (actual === expected)
            else begin
                $display("TB FAILED");
                $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
                $fatal(1, "mismatch on %s", name);
            end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("TB FAILED");
        $display("timeout while waiting for %s", what);
        $fatal(1, "timeout");
    endtask

    // falling edge, inputs and state settled
    task automatic check_outputs();
        logic [W-1:0] ret;
        logic         chain;
        int           free;
        int           t;
        ret  = expected_retire();
        free = L - count_busy();
        if (free > W) free = W;
        expect_value("free_slots", 64'(free), 64'(free_slots));
        chain = 1'b1;
        for (int k = 0; k < W; k++) begin
            chain = chain & dispatch_in[k].valid;
            t     = (m_tail + k) % L;
            expect_value($sformatf("map_out[%0d].valid", k),
                         64'(chain & dispatch_in[k].dest_valid), 64'(map_out[k].valid));
            if (chain) begin
                expect_value($sformatf("map_out[%0d].tag", k), 64'(t), 64'(map_out[k].tag));
                expect_value($sformatf("map_out[%0d].dest_reg", k),
                             64'(dispatch_in[k].dest_valid ? dispatch_in[k].dest_reg : 5'd0),
                             64'(map_out[k].dest_reg));
            end
        end
        for (int k = 0; k < W; k++) begin
            t = (m_head + k) % L;  // program order from head
            expect_value($sformatf("retire_out[%0d].valid", k), 64'(ret[k]),
                         64'(retire_out[k].valid));
            if (ret[k]) begin
                expect_value($sformatf("retire_out[%0d].tag", k), 64'(t),
                             64'(retire_out[k].tag));
                expect_value($sformatf("retire_out[%0d].dest_reg", k), 64'(m_dest[t]),
                             64'(retire_out[k].dest_reg));
                expect_value($sformatf("retire_out[%0d].value", k), 64'(m_val[t]),
                             64'(retire_out[k].value));
                expect_value($sformatf("retire_out[%0d].take_branch", k), 64'(m_br[t]),
                             64'(retire_out[k].take_branch));
            end
        end
    endtask

    task automatic run_cycle(input logic new_work);
        @(posedge clock);
        model_step();
        drive_stimulus(new_work);
        @(negedge clock);
        check_outputs();
    endtask

    initial begin
        int waited;
        seed        = 32'h3064_bff1;
        rst_n       = 1'b0;
        squash      = 1'b0;
        dispatch_in = '0;
        complete_in = '0;
        model_clear();
        repeat (3) begin
            @(posedge clock);
            model_step();
        end
        rst_n <= 1'b1;
        waited = 0;
        while (free_slots !== rob_pkg::lane_cnt_t'(W) || retire_out[0].valid !== 1'b0) begin
            @(negedge clock);
            waited++;
            if (waited > 10) abort_on_timeout("the buffer to come out of reset");
        end
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) run_cycle(1'b1);
        // no new work, let every entry complete and retire
        waited = 0;
        while (count_busy() != 0) begin
            run_cycle(1'b0);
            waited++;
            if (waited > 200) abort_on_timeout("the buffer to drain");
        end
        if (dut.u_checker.fail_count != 0) begin
            $display("TB FAILED");
            $fatal(1, "bound assertions reported %0d failures", dut.u_checker.fail_count);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entry_table.sv
rtl/rob_retire_sel.sv
rtl/rob_top.sv
sim/rob_checker.sv
sim/tb_rob.sv
